//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem1_stage
RTL_TOP   ?= mem1_stage
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
+incdir+hdl
hdl/mem_access_pkg.sv
hdl/addr_translate.sv
hdl/exc_prioritize.sv
hdl/ll_reservation.sv
hdl/store_align.sv
hdl/mem1_stage.sv
testbench/tb_mem1_stage.sv

//--- hdl/addr_translate.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_access_config.svh"

module addr_translate
    import mem_access_pkg::*;
(
    input  wire mem_op_e                 op,
    input  wire [`MA_ADDR_W-1:0]         vaddr,
    input  wire tlb_resp_t               tlb,
    input  wire [`MA_ATTR_W-1:0]         k0_attr,
    output logic [`MA_ADDR_W-1:0]        paddr,
    output logic                         mapped,
    output logic                         uncached
);

    logic [2:0]            seg;
    logic                  kseg0;
    logic                  kseg1;
    logic [`MA_ATTR_W-1:0] attr;

    assign seg   = vaddr[`MA_ADDR_W-1 -: 3];
    assign kseg0 = (seg == `MA_SEG_KSEG0);
    assign kseg1 = (seg == `MA_SEG_KSEG1);

    // kuseg, kseg2 and kseg3 go through the TLB
    assign mapped = (op != op_none) && !kseg0 && !kseg1;

    always_comb begin
        if (mapped) begin
            paddr = {tlb.pfn, vaddr[`MA_OFS_W-1:0]};
        end else begin
            paddr = {3'b000, vaddr[`MA_ADDR_W-4:0]}; // strip segment bits
        end
    end

    assign attr     = kseg0 ? k0_attr : tlb.c; // Config.K0 or entry C bits
    assign uncached = kseg1 || (attr != `MA_ATTR_CACHED);

    always_comb begin
        assert #0 (!kseg1 || uncached)
            else $error("kseg1 access marked cached, vaddr %h", vaddr);
    end

endmodule

`default_nettype wire

//--- hdl/exc_prioritize.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_access_config.svh"

module exc_prioritize
    import mem_access_pkg::*;
(
    input  wire mem_req_t  req,
    input  wire tlb_resp_t tlb,
    input  wire            mapped,
    input  wire            interrupt,
    input  wire            overflow,
    input  wire            trap,
    input  wire exc_info_t upstream,
    output exc_info_t      exc,
    output logic           tlb_refill
);

    logic load;
    logic store;
    logic no_up;
    logic ades;
    logic adel;
    logic entry_bad;
    logic tlbl;
    logic tlbs;
    logic tlb_mod;

    assign load  = is_load(req.op);
    assign store = is_store(req.op);
    assign no_up = !upstream.valid;

    // lwl/lwr/swl/swr take any byte address
    assign ades = no_up && store &&
                  ((req.op == op_sh && req.vaddr[0]) ||
                   ((req.op == op_sw || req.op == op_sc) && req.vaddr[1:0] != 2'b00));
    assign adel = no_up && load &&
                  ((req.op == op_lh && req.vaddr[0]) ||
                   ((req.op == op_lw || req.op == op_ll) && req.vaddr[1:0] != 2'b00));

    assign entry_bad = !tlb.found || !tlb.v; // refill or invalid
    assign tlbl    = no_up && mapped && load && entry_bad;
    assign tlbs    = no_up && mapped && store && entry_bad;
    assign tlb_mod = no_up && mapped && store && tlb.found && tlb.v && !tlb.d;

    assign tlb_refill = no_up && mapped && !tlb.found; // goes to the refill vector

    always_comb begin
        exc.valid    = 1'b1;
        exc.code     = exc_int;
        exc.badvaddr = '0;
        if (interrupt) begin
            exc.code = exc_int;
        end else if (overflow && no_up) begin
            exc.code = exc_ov;
        end else if (trap && no_up) begin
            exc.code = exc_tr;
        end else if (ades) begin
            exc.code     = exc_ades;
            exc.badvaddr = req.vaddr;
        end else if (adel) begin
            exc.code     = exc_adel;
            exc.badvaddr = req.vaddr;
        end else if (tlbl) begin
            exc.code     = exc_tlbl;
            exc.badvaddr = req.vaddr;
        end else if (tlbs) begin
            exc.code     = exc_tlbs;
            exc.badvaddr = req.vaddr;
        end else if (tlb_mod) begin
            exc.code     = exc_mod;
            exc.badvaddr = req.vaddr;
        end else if (upstream.valid) begin
            // earlier address faults are on the fetch, so pc is the bad address
            exc.code     = upstream.code;
            exc.badvaddr = req.pc;
        end else begin
            exc.valid = 1'b0;
            exc.code  = exc_none;
        end
    end

    always_comb begin
        assert #0 (!exc.valid || exc.code != exc_none)
            else $error("exception raised with no cause code");
    end

endmodule

`default_nettype wire

//--- hdl/ll_reservation.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_access_config.svh"

module ll_reservation
    import mem_access_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire mem_req_t req,
    input  wire           exc_valid,
    input  wire           eret_flush,
    output logic          sc_ok
);

    logic                  ll_bit;
    logic [`MA_ADDR_W-1:0] ll_addr;

    // an exception or eret breaks the LL/SC sequence
    always_ff @(posedge clk) begin
        if (!rst_n || exc_valid || eret_flush) begin
            ll_bit <= 1'b0;
        end else if (req.op == op_ll) begin
            ll_bit <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req.op == op_ll) begin
            ll_addr <= req.vaddr; // virtual address of the link
        end
    end

    assign sc_ok = (req.op == op_sc) && ll_bit && (ll_addr == req.vaddr);

    a_clear_on_exc: assert property (@(posedge clk) exc_valid |=> !ll_bit)
        else $error("LL reservation survived an exception");

endmodule

`default_nettype wire

//--- hdl/mem1_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_access_config.svh"

module mem1_stage
    import mem_access_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire mem_req_t         req,
    input  wire tlb_resp_t        tlb,
    input  wire [`MA_ATTR_W-1:0]  k0_attr,
    input  wire                   interrupt,
    input  wire                   overflow,
    input  wire                   trap,
    input  wire                   eret_flush,
    input  wire exc_info_t        upstream,
    output logic [`MA_ADDR_W-1:0] paddr,
    output logic                  uncached,
    output logic                  dcache_valid,
    output logic                  uncache_valid,
    output store_t                store,
    output exc_info_t             exc,
    output logic                  tlb_refill,
    output logic [`MA_ADDR_W-1:0] sc_result
);

    logic mapped;
    logic sc_ok;
    logic sc_fail;
    logic wen;
    logic access_ok;

    addr_translate addr_translate_i (
        .op       (req.op),
        .vaddr    (req.vaddr),
        .tlb      (tlb),
        .k0_attr  (k0_attr),
        .paddr    (paddr),
        .mapped   (mapped),
        .uncached (uncached)
    );

    exc_prioritize exc_prioritize_i (
        .req        (req),
        .tlb        (tlb),
        .mapped     (mapped),
        .interrupt  (interrupt),
        .overflow   (overflow),
        .trap       (trap),
        .upstream   (upstream),
        .exc        (exc),
        .tlb_refill (tlb_refill)
    );

    ll_reservation ll_reservation_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .exc_valid  (exc.valid),
        .eret_flush (eret_flush),
        .sc_ok      (sc_ok)
    );

    assign sc_fail = (req.op == op_sc) && !sc_ok; // sc without a live link

    assign wen = is_store(req.op) && !exc.valid && !eret_flush && !sc_fail;

    store_align store_align_i (
        .op      (req.op),
        .rt_data (req.rt_data),
        .addr_lo (paddr[1:0]),
        .wen     (wen),
        .store   (store)
    );

    assign access_ok     = (req.op != op_none) && !exc.valid && !eret_flush && !sc_fail;
    assign dcache_valid  = access_ok && !uncached;
    assign uncache_valid = access_ok && uncached;

    // written back to rt by sc
    assign sc_result = {{(`MA_ADDR_W-1){1'b0}}, dcache_valid | uncache_valid};

    a_one_path: assert property (@(posedge clk) disable iff (!rst_n)
        !(dcache_valid && uncache_valid))
        else $error("request sent to both cached and uncached paths");

endmodule

`default_nettype wire

//--- hdl/mem_access_config.svh
`ifndef MEM_ACCESS_CONFIG_SVH
`define MEM_ACCESS_CONFIG_SVH

// address and data word width
`define MA_ADDR_W 32

// physical frame number and page offset of 4 KB pages
`define MA_PFN_W 20
`define MA_OFS_W 12

// cache attribute field as in Config.K0 and the TLB C bits
`define MA_ATTR_W 3
`define MA_ATTR_CACHED 3'd3

// vaddr[31:29] of the unmapped segments
`define MA_SEG_KSEG0 3'd4
`define MA_SEG_KSEG1 3'd5

`endif

//--- hdl/mem_access_pkg.sv
`default_nettype none
`include "mem_access_config.svh"

package mem_access_pkg;

    typedef enum logic [3:0] {
        op_none,
        op_lb,
        op_lh,
        op_lw,
        op_lwl,
        op_lwr,
        op_ll,
        op_sb,
        op_sh,
        op_sw,
        op_swl,
        op_swr,
        op_sc
    } mem_op_e;

    // CP0 Cause.ExcCode values
    typedef enum logic [4:0] {
        exc_int  = 5'd0,
        exc_mod  = 5'd1,
        exc_tlbl = 5'd2,
        exc_tlbs = 5'd3,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_ov   = 5'd12,
        exc_tr   = 5'd13,
        exc_none = 5'd31
    } exc_code_e;

    typedef struct packed {
        mem_op_e               op;
        logic [`MA_ADDR_W-1:0] vaddr;
        logic [`MA_ADDR_W-1:0] rt_data;
        logic [`MA_ADDR_W-1:0] pc;
    } mem_req_t;

    typedef struct packed {
        logic                  found;
        logic                  v;
        logic                  d;
        logic [`MA_PFN_W-1:0]  pfn;
        logic [`MA_ATTR_W-1:0] c;
    } tlb_resp_t;

    typedef struct packed {
        logic                  valid;
        exc_code_e             code;
        logic [`MA_ADDR_W-1:0] badvaddr;
    } exc_info_t;

    typedef struct packed {
        logic [3:0]            wstrb;
        logic [`MA_ADDR_W-1:0] wdata;
    } store_t;

    function automatic logic is_load(mem_op_e op);
        return op inside {op_lb, op_lh, op_lw, op_lwl, op_lwr, op_ll};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {op_sb, op_sh, op_sw, op_swl, op_swr, op_sc};
    endfunction

endpackage

`default_nettype wire

//--- hdl/store_align.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_access_config.svh"

module store_align
    import mem_access_pkg::*;
(
    input  wire mem_op_e         op,
    input  wire [`MA_ADDR_W-1:0] rt_data,
    input  wire [1:0]            addr_lo,
    input  wire                  wen,
    output store_t               store
);

    logic [3:0]            wstrb;
    logic [`MA_ADDR_W-1:0] wdata;

    always_comb begin
        wstrb = 4'b0000;
        if (wen) begin
            case (op)
                op_sb:   wstrb = 4'b0001 << addr_lo;
                op_sh:   wstrb = addr_lo[1] ? 4'b1100 : 4'b0011;
                op_sw,
                op_sc:   wstrb = 4'b1111;
                op_swl:  wstrb = 4'b1111 >> ~addr_lo; // low bytes up to addr
                op_swr:  wstrb = 4'b1111 << addr_lo;  // addr up to the top byte
                default: wstrb = 4'b0000;
            endcase
        end
    end

    // swl/swr place the partial word so the strobes pick the right bytes
    always_comb begin
        wdata = rt_data;
        if (op == op_swl) begin
            case (wstrb)
                4'b0001: wdata = {4{rt_data[31:24]}};
                4'b0011: wdata = {2{rt_data[31:16]}};
                4'b0111: wdata = {8'b0, rt_data[31:8]};
                default: wdata = rt_data;
            endcase
        end else if (op == op_swr) begin
            case (wstrb)
                4'b1000: wdata = {4{rt_data[7:0]}};
                4'b1100: wdata = {2{rt_data[15:0]}};
                4'b1110: wdata = {rt_data[23:0], 8'b0};
                default: wdata = rt_data;
            endcase
        end
    end

    assign store.wstrb = wstrb;
    assign store.wdata = wdata;

    // a write enable only ever comes with a store op
    always_comb begin
        assert #0 ((wstrb != 4'b0000) == wen)
            else $error("byte strobes do not match write enable, op %s", op.name());
    end

endmodule

`default_nettype wire

//--- testbench/tb_mem1_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "mem_access_config.svh"

module tb_mem1_stage
    import mem_access_pkg::*;
();

    localparam int SETTLE     = 5;
    localparam int MAX_CYCLES = 200; // about twice the directed test length

    logic                  clk;
    logic                  rst_n;
    mem_req_t              req;
    tlb_resp_t             tlb;
    logic [`MA_ATTR_W-1:0] k0_attr;
    logic                  interrupt;
    logic                  overflow;
    logic                  trap;
    logic                  eret_flush;
    exc_info_t             upstream;
    logic [`MA_ADDR_W-1:0] paddr;
    logic                  uncached;
    logic                  dcache_valid;
    logic                  uncache_valid;
    store_t                store;
    exc_info_t             exc;
    logic                  tlb_refill;
    logic [`MA_ADDR_W-1:0] sc_result;
    int                    cycles = 0;

    mem1_stage mem1_stage_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .tlb           (tlb),
        .k0_attr       (k0_attr),
        .interrupt     (interrupt),
        .overflow      (overflow),
        .trap          (trap),
        .eret_flush    (eret_flush),
        .upstream      (upstream),
        .paddr         (paddr),
        .uncached      (uncached),
        .dcache_valid  (dcache_valid),
        .uncache_valid (uncache_valid),
        .store         (store),
        .exc           (exc),
        .tlb_refill    (tlb_refill),
        .sc_result     (sc_result)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $fatal(1, "simulation timeout");
        end
    end

    function automatic mem_req_t mk_req(mem_op_e op, logic [31:0] va, logic [31:0] rt,
                                        logic [31:0] pc);
        mem_req_t r;
        r.op      = op;
        r.vaddr   = va;
        r.rt_data = rt;
        r.pc      = pc;
        return r;
    endfunction

    function automatic tlb_resp_t mk_tlb(logic found, logic v, logic d, logic [19:0] pfn,
                                         logic [2:0] c);
        tlb_resp_t t;
        t.found = found;
        t.v     = v;
        t.d     = d;
        t.pfn   = pfn;
        t.c     = c;
        return t;
    endfunction

    function automatic exc_info_t mk_exc(logic valid, exc_code_e code, logic [31:0] bv);
        exc_info_t e;
        e.valid    = valid;
        e.code     = code;
        e.badvaddr = bv;
        return e;
    endfunction

    function automatic store_t mk_store(logic [3:0] wstrb, logic [31:0] wdata);
        store_t s;
        s.wstrb = wstrb;
        s.wdata = wdata;
        return s;
    endfunction

    // halfword needs bit 0 clear, word needs both low bits clear
    function automatic logic misaligned(mem_op_e op, logic [1:0] lo);
        case (op)
            op_lh, op_sh:               return lo[0];
            op_lw, op_ll, op_sw, op_sc: return lo != 2'b00;
            default:                    return 1'b0;
        endcase
    endfunction

    function automatic logic [3:0] strobe_table(mem_op_e op, logic [1:0] lo);
        logic [15:0] row; // offsets 3..0
        case (op)
            op_sb:        row = {4'b1000, 4'b0100, 4'b0010, 4'b0001};
            op_sh:        row = {4'b1100, 4'b1100, 4'b0011, 4'b0011};
            op_sw, op_sc: row = {4'b1111, 4'b1111, 4'b1111, 4'b1111};
            op_swl:       row = {4'b1111, 4'b0111, 4'b0011, 4'b0001};
            op_swr:       row = {4'b1000, 4'b1100, 4'b1110, 4'b1111};
            default:      row = 16'h0000;
        endcase
        return row[{lo, 2'b00} +: 4];
    endfunction

    function automatic logic [31:0] expected_wdata(mem_op_e op, logic [3:0] strb,
                                                   logic [31:0] rt);
        if (op == op_swl && strb == 4'b0001) return {4{rt[31:24]}};
        if (op == op_swl && strb == 4'b0011) return {2{rt[31:16]}};
        if (op == op_swl && strb == 4'b0111) return {8'h00, rt[31:8]};
        if (op == op_swr && strb == 4'b1000) return {4{rt[7:0]}};
        if (op == op_swr && strb == 4'b1100) return {2{rt[15:0]}};
        if (op == op_swr && strb == 4'b1110) return {rt[23:0], 8'h00};
        return rt;
    endfunction

    task automatic fail_value(input string name, input string exp_s, input string act_s);
        $display("FAILED at %0t ns: %s expected %s, got %s", $time, name, exp_s, act_s);
        $display("TESTS FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic check_addr(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) fail_value(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) fail_value(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_exc(input string name, input exc_info_t exp, input exc_info_t act);
        if (act !== exp) begin
            fail_value(name, $sformatf("%b/%s/%h", exp.valid, exp.code.name(), exp.badvaddr),
                       $sformatf("%b/%s/%h", act.valid, act.code.name(), act.badvaddr));
        end
    endtask

    task automatic check_store(input string name, input store_t exp, input store_t act);
        if (act !== exp) begin
            fail_value(name, $sformatf("%b/%h", exp.wstrb, exp.wdata),
                       $sformatf("%b/%h", act.wstrb, act.wdata));
        end
    endtask

    // ev is {interrupt, overflow, trap, eret_flush}
    task automatic issue(input mem_req_t r, input tlb_resp_t t, input logic [2:0] k0,
                         input logic [3:0] ev, input exc_info_t up);
        @(posedge clk);
        req        <= r;
        tlb        <= t;
        k0_attr    <= k0;
        interrupt  <= ev[3];
        overflow   <= ev[2];
        trap       <= ev[1];
        eret_flush <= ev[0];
        upstream   <= up;
        #SETTLE;
    endtask

    task automatic check_no_request(input logic [31:0] rt);
        check_bit("dcache_valid", 1'b0, dcache_valid);
        check_bit("uncache_valid", 1'b0, uncache_valid);
        check_store("store", mk_store(4'b0000, rt), store);
    endtask

    task automatic test_direct();
        logic [31:0] va;
        logic [2:0]  k0;
        logic        exp_unc;
        for (int i = 0; i < 16; i++) begin
            va        = $urandom & 32'h1fff_fffc;
            va[31:29] = (i < 8) ? `MA_SEG_KSEG0 : `MA_SEG_KSEG1;
            k0        = i[0] ? `MA_ATTR_CACHED : 3'($urandom % 3);
            issue(mk_req(op_lw, va, $urandom, $urandom),
                  mk_tlb(1'b0, 1'b0, 1'b0, 20'($urandom), 3'($urandom)), k0, 4'b0000,
                  mk_exc(1'b0, exc_none, '0));
            exp_unc = (va[31:29] == `MA_SEG_KSEG1) || (k0 != `MA_ATTR_CACHED);
            check_addr("paddr", {3'b000, va[28:0]}, paddr);
            check_bit("uncached", exp_unc, uncached);
            check_bit("dcache_valid", !exp_unc, dcache_valid);
            check_bit("uncache_valid", exp_unc, uncache_valid);
            check_bit("exc.valid", 1'b0, exc.valid);
            check_bit("tlb_refill", 1'b0, tlb_refill);
        end
    endtask

    task automatic test_mapped();
        logic [31:0] va;
        tlb_resp_t   t;
        mem_req_t    r;
        logic        exp_unc;
        for (int i = 0; i < 6; i++) begin
            va = $urandom & 32'h7fff_fffc; // kuseg
            t  = mk_tlb(1'b1, 1'b1, 1'b1, 20'($urandom),
                        i[0] ? `MA_ATTR_CACHED : 3'($urandom % 3));
            issue(mk_req(op_lw, va, $urandom, $urandom), t, `MA_ATTR_CACHED, 4'b0000,
                  mk_exc(1'b0, exc_none, '0));
            exp_unc = (t.c != `MA_ATTR_CACHED);
            check_addr("paddr", {t.pfn, va[11:0]}, paddr);
            check_bit("uncached", exp_unc, uncached);
            check_bit("dcache_valid", !exp_unc, dcache_valid);
            check_bit("uncache_valid", exp_unc, uncache_valid);
            check_bit("exc.valid", 1'b0, exc.valid);
        end
        r = mk_req(op_lw, $urandom & 32'h7fff_fffc, $urandom, $urandom); // refill miss
        issue(r, mk_tlb(1'b0, 1'b0, 1'b0, 20'($urandom), `MA_ATTR_CACHED), `MA_ATTR_CACHED,
              4'b0000, mk_exc(1'b0, exc_none, '0));
        check_exc("exc", mk_exc(1'b1, exc_tlbl, r.vaddr), exc);
        check_bit("tlb_refill", 1'b1, tlb_refill);
        check_no_request(r.rt_data);
        r = mk_req(op_sw, $urandom & 32'h7fff_fffc, $urandom, $urandom);
        issue(r, mk_tlb(1'b1, 1'b0, 1'b1, 20'($urandom), `MA_ATTR_CACHED), `MA_ATTR_CACHED,
              4'b0000, mk_exc(1'b0, exc_none, '0));
        check_exc("exc", mk_exc(1'b1, exc_tlbs, r.vaddr), exc);
        check_bit("tlb_refill", 1'b0, tlb_refill);
        check_no_request(r.rt_data);
        r = mk_req(op_sw, $urandom & 32'h7fff_fffc, $urandom, $urandom); // clean page
        issue(r, mk_tlb(1'b1, 1'b1, 1'b0, 20'($urandom), `MA_ATTR_CACHED), `MA_ATTR_CACHED,
              4'b0000, mk_exc(1'b0, exc_none, '0));
        check_exc("exc", mk_exc(1'b1, exc_mod, r.vaddr), exc);
        check_bit("tlb_refill", 1'b0, tlb_refill);
        check_no_request(r.rt_data);
    endtask

    task automatic test_priority();
        mem_op_e     ops [4] = '{op_lh, op_lw, op_sh, op_sw};
        logic [1:0]  los [4] = '{2'd1, 2'd2, 2'd3, 2'd1};
        logic [31:0] base;
        mem_req_t    r;
        tlb_resp_t   t;
        exc_info_t   none;
        base      = $urandom & 32'h1fff_fffc;
        base[31:29] = `MA_SEG_KSEG0;
        t         = mk_tlb(1'b1, 1'b1, 1'b1, '0, `MA_ATTR_CACHED);
        none      = mk_exc(1'b0, exc_none, '0);
        for (int i = 0; i < 4; i++) begin
            r = mk_req(ops[i], base | {30'b0, los[i]}, $urandom, $urandom);
            issue(r, t, `MA_ATTR_CACHED, 4'b0000, none);
            check_exc("exc", mk_exc(1'b1, i < 2 ? exc_adel : exc_ades, r.vaddr), exc);
            check_no_request(r.rt_data);
        end
        r = mk_req(op_lwl, base | 32'd1, $urandom, $urandom);
        issue(r, t, `MA_ATTR_CACHED, 4'b0000, none);
        check_bit("exc.valid", 1'b0, exc.valid);
        check_bit("dcache_valid", 1'b1, dcache_valid);
        r = mk_req(op_swr, base | 32'd3, $urandom, $urandom);
        issue(r, t, `MA_ATTR_CACHED, 4'b0000, none);
        check_bit("exc.valid", 1'b0, exc.valid);
        check_store("store", mk_store(4'b1000, {4{r.rt_data[7:0]}}), store);
        r = mk_req(op_sw, base | 32'd2, $urandom, $urandom);
        issue(r, t, `MA_ATTR_CACHED, 4'b1110, none);
        check_exc("exc", mk_exc(1'b1, exc_int, '0), exc);
        issue(r, t, `MA_ATTR_CACHED, 4'b0110, none);
        check_exc("exc", mk_exc(1'b1, exc_ov, '0), exc);
        issue(r, t, `MA_ATTR_CACHED, 4'b0010, none);
        check_exc("exc", mk_exc(1'b1, exc_tr, '0), exc);
        issue(r, t, `MA_ATTR_CACHED, 4'b0000, none);
        check_exc("exc", mk_exc(1'b1, exc_ades, r.vaddr), exc);
        r = mk_req(op_lw, base, $urandom, $urandom);
        issue(r, t, `MA_ATTR_CACHED, 4'b0100, mk_exc(1'b1, exc_adel, $urandom));
        check_exc("exc", mk_exc(1'b1, exc_adel, r.pc), exc); // overflow ignored
        check_no_request(r.rt_data);
    endtask

    task automatic test_store_align();
        mem_op_e     ops [5] = '{op_sb, op_sh, op_sw, op_swl, op_swr};
        logic [31:0] va;
        logic [31:0] rt;
        logic [1:0]  lo;
        logic [3:0]  strb;
        logic        mis;
        for (int n = 0; n < 2; n++) begin
            for (int k = 0; k < 5; k++) begin
                for (int off = 0; off < 4; off++) begin
                    lo        = 2'(off);
                    va        = ($urandom & 32'h1fff_fffc) | {30'b0, lo};
                    va[31:29] = `MA_SEG_KSEG1;
                    rt        = $urandom;
                    issue(mk_req(ops[k], va, rt, $urandom),
                          mk_tlb(1'b0, 1'b0, 1'b0, '0, '0), `MA_ATTR_CACHED, 4'b0000,
                          mk_exc(1'b0, exc_none, '0));
                    mis  = misaligned(ops[k], lo);
                    strb = mis ? 4'b0000 : strobe_table(ops[k], lo);
                    check_store("store", mk_store(strb, expected_wdata(ops[k], strb, rt)),
                                store);
                    check_bit("uncache_valid", !mis, uncache_valid);
                end
            end
        end
    endtask

    task automatic check_sc_failed(input logic [31:0] rt);
        check_addr("sc_result", 32'd0, sc_result);
        check_no_request(rt);
    endtask

    task automatic test_ll_sc();
        logic [31:0] a;
        logic [31:0] rt;
        tlb_resp_t   t;
        exc_info_t   none;
        a       = $urandom & 32'h1fff_fffc;
        a[31:29] = `MA_SEG_KSEG0;
        rt      = $urandom;
        t       = mk_tlb(1'b1, 1'b1, 1'b1, '0, `MA_ATTR_CACHED);
        none    = mk_exc(1'b0, exc_none, '0);
        issue(mk_req(op_ll, a, '0, '0), t, `MA_ATTR_CACHED, 4'b0000, none);
        check_bit("dcache_valid", 1'b1, dcache_valid);
        issue(mk_req(op_sc, a, rt, '0), t, `MA_ATTR_CACHED, 4'b0000, none);
        check_addr("sc_result", 32'd1, sc_result);
        check_bit("dcache_valid", 1'b1, dcache_valid);
        check_store("store", mk_store(4'b1111, rt), store);
        issue(mk_req(op_ll, a, '0, '0), t, `MA_ATTR_CACHED, 4'b0000, none);
        issue(mk_req(op_sc, a ^ 32'h10, rt, '0), t, `MA_ATTR_CACHED, 4'b0000, none);
        check_sc_failed(rt);
        issue(mk_req(op_ll, a, '0, '0), t, `MA_ATTR_CACHED, 4'b0000, none);
        issue(mk_req(op_none, '0, '0, '0), t, `MA_ATTR_CACHED, 4'b0001, none); // eret
        issue(mk_req(op_sc, a, rt, '0), t, `MA_ATTR_CACHED, 4'b0000, none);
        check_sc_failed(rt);
        issue(mk_req(op_ll, a, '0, '0), t, `MA_ATTR_CACHED, 4'b0000, none);
        issue(mk_req(op_none, '0, '0, '0), t, `MA_ATTR_CACHED, 4'b1000, none); // interrupt
        issue(mk_req(op_sc, a, rt, '0), t, `MA_ATTR_CACHED, 4'b0000, none);
        check_sc_failed(rt);
        issue(mk_req(op_ll, a, '0, '0), t, `MA_ATTR_CACHED, 4'b0000, none);
        @(posedge clk);
        rst_n <= 1'b0;
        req   <= mk_req(op_none, '0, '0, '0);
        @(posedge clk);
        rst_n <= 1'b1;
        issue(mk_req(op_sc, a, rt, '0), t, `MA_ATTR_CACHED, 4'b0000, none);
        check_sc_failed(rt);
    endtask

    initial begin
        void'($urandom(32'hfa4d7b3b));
        clk        = 1'b0;
        rst_n      = 1'b0;
        req        = mk_req(op_none, '0, '0, '0);
        tlb        = mk_tlb(1'b0, 1'b0, 1'b0, '0, '0);
        k0_attr    = `MA_ATTR_CACHED;
        interrupt  = 1'b0;
        overflow   = 1'b0;
        trap       = 1'b0;
        eret_flush = 1'b0;
        upstream   = mk_exc(1'b0, exc_none, '0);
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        #SETTLE;
        check_bit("dcache_valid", 1'b0, dcache_valid);
        check_bit("uncache_valid", 1'b0, uncache_valid);
        check_store("store", mk_store(4'b0000, '0), store);
        test_direct();
        test_mapped();
        test_priority();
        test_store_align();
        test_ll_sc();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
